// File: rtl/procPkg.sv
package procPkg;

    localparam int dataWidth = 16;
    localparam int regCount  = 8;

    typedef logic [dataWidth-1:0] dataT;
    typedef logic [dataWidth-1:0] instrT;
    typedef logic [2:0]           regIdxT;

    // Instruction field positions
    localparam int opMsb    = 15;
    localparam int opLsb    = 12;
    localparam int rdMsb    = 11;
    localparam int rdLsb    = 9;
    localparam int rsMsb    = 8;
    localparam int rsLsb    = 6;
    localparam int rtMsb    = 5;
    localparam int rtLsb    = 3;
    localparam int immMsb   = 5;
    localparam int immLsb   = 0;
    localparam int immWidth = immMsb - immLsb + 1;

    // Opcode zero is NOP so an all-zero word is harmless
    // ST writes rt to address rs; BEQZ jumps to pc + 1 + imm when rs is zero
    typedef enum logic [3:0] {
        opNop  = 4'h0,
        opAdd  = 4'h1,
        opSub  = 4'h2,
        opAnd  = 4'h3,
        opOr   = 4'h4,
        opXor  = 4'h5,
        opAddi = 4'h6,
        opLd   = 4'h7,
        opSt   = 4'h8,
        opBeqz = 4'h9,
        opHalt = 4'hF
    } opcodeT;

    localparam instrT nopInstr = instrT'({opNop, 12'h000});

    // Ops that write rd
    function automatic logic writesRd(opcodeT op);
        return op inside {opAdd, opSub, opAnd, opOr, opXor, opAddi, opLd};
    endfunction

    function automatic logic isLegal(opcodeT op);
        return op inside {opNop, opAdd, opSub, opAnd, opOr, opXor, opAddi,
                          opLd, opSt, opBeqz, opHalt};
    endfunction

endpackage

// File: rtl/fetchStage.sv
`timescale 1ns/1ps

module fetchStage #(
    parameter int imemAddrWidth = 6
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     loadEn,
    input  logic [imemAddrWidth-1:0] loadAddr,
    input  procPkg::instrT           loadData,
    input  logic                     stall,
    input  logic                     redirect,
    input  procPkg::dataT            redirectPc,
    input  logic                     freeze,
    output procPkg::instrT           ifIdInstr,
    output procPkg::dataT            ifIdPc,
    output logic                     ifIdValid
);

    import procPkg::*;

    localparam int imemDepth = 1 << imemAddrWidth;

    instrT imem [imemDepth];
    dataT  pc;
    instrT fetchInstr;
    logic  pcInRange;

    // Program load port, used while the core sits in reset
    always_ff @(posedge clk) begin
        if (loadEn) begin
            imem[loadAddr] <= loadData;
        end
    end

    // Past the end of the array the core just sees NOPs
    assign pcInRange  = 32'(pc) < imemDepth;
    assign fetchInstr = pcInRange ? imem[pc[imemAddrWidth-1:0]] : nopInstr;

    // PC and IF/ID valid; redirect beats freeze beats stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc        <= '0;
            ifIdValid <= 1'b0;
        end else if (redirect) begin
            pc        <= redirectPc;
            ifIdValid <= 1'b0;
        end else if (freeze) begin
            ifIdValid <= 1'b0;
        end else if (!stall) begin
            pc        <= pc + dataT'(1);
            ifIdValid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ifIdInstr <= fetchInstr;
            ifIdPc    <= pc;
        end
    end

endmodule

// File: rtl/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
    input  logic             clk,
    input  logic             rstN,
    input  procPkg::instrT   ifIdInstr,
    input  procPkg::dataT    ifIdPc,
    input  logic             ifIdValid,
    input  logic             redirect,
    input  logic             wbValid,
    input  procPkg::regIdxT  wbReg,
    input  procPkg::dataT    wbData,
    output logic             stall,
    output logic             idExValid,
    output procPkg::opcodeT  idExOp,
    output procPkg::regIdxT  idExRd,
    output procPkg::regIdxT  idExRs,
    output procPkg::regIdxT  idExRt,
    output procPkg::dataT    idExA,
    output procPkg::dataT    idExB,
    output procPkg::dataT    idExImm,
    output procPkg::dataT    idExPc
);

    import procPkg::*;

    opcodeT op;
    regIdxT rd;
    regIdxT rs;
    regIdxT rt;
    dataT   imm;
    dataT   regs [regCount];
    dataT   rsVal;
    dataT   rtVal;
    logic   usesRs;
    logic   usesRt;
    logic   loadUse;

    // Register read with r0 tied to zero and writeback passed through
    function automatic dataT readPort(regIdxT idx);
        dataT val;
        val = regs[idx];
        if (idx == '0) begin
            val = '0;
        end else if (wbValid && wbReg == idx) begin
            val = wbData;
        end
        return val;
    endfunction

    // Field split; an illegal opcode is kept as is for execute
    assign op  = opcodeT'(ifIdInstr[opMsb:opLsb]);
    assign rd  = ifIdInstr[rdMsb:rdLsb];
    assign rs  = ifIdInstr[rsMsb:rsLsb];
    assign rt  = ifIdInstr[rtMsb:rtLsb];
    assign imm = {{(dataWidth - immWidth){ifIdInstr[immMsb]}}, ifIdInstr[immMsb:immLsb]};

    always_comb begin
        rsVal = readPort(rs);
        rtVal = readPort(rt);
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbValid) begin
            regs[wbReg] <= wbData;
        end
    end

    // Which source fields the instruction really reads
    always_comb begin
        usesRs = writesRd(op) || op == opSt || op == opBeqz;
        usesRt = op inside {opAdd, opSub, opAnd, opOr, opXor, opSt};
    end

    // Load in ID/EX feeding the instruction behind it
    assign loadUse = idExValid && idExOp == opLd && idExRd != '0 &&
                     ((usesRs && rs == idExRd) || (usesRt && rt == idExRd));
    assign stall   = ifIdValid && loadUse;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idExValid <= 1'b0;
            idExOp    <= opNop;
        end else if (redirect || stall) begin
            // Bubble
            idExValid <= 1'b0;
            idExOp    <= opNop;
        end else begin
            idExValid <= ifIdValid;
            idExOp    <= op;
        end
    end

    always_ff @(posedge clk) begin
        idExRd  <= rd;
        idExRs  <= rs;
        idExRt  <= rt;
        idExA   <= rsVal;
        idExB   <= rtVal;
        idExImm <= imm;
        idExPc  <= ifIdPc;
    end

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             idExValid,
    input  procPkg::opcodeT  idExOp,
    input  procPkg::regIdxT  idExRd,
    input  procPkg::regIdxT  idExRs,
    input  procPkg::regIdxT  idExRt,
    input  procPkg::dataT    idExA,
    input  procPkg::dataT    idExB,
    input  procPkg::dataT    idExImm,
    input  procPkg::dataT    idExPc,
    input  logic             wbValid,
    input  procPkg::regIdxT  wbReg,
    input  procPkg::dataT    wbData,
    output logic             redirect,
    output procPkg::dataT    redirectPc,
    output logic             freeze,
    output logic             exMemValid,
    output procPkg::opcodeT  exMemOp,
    output procPkg::regIdxT  exMemRd,
    output procPkg::dataT    exMemResult,
    output procPkg::dataT    exMemStore
);

    import procPkg::*;

    typedef enum logic [1:0] {fwdReg, fwdExMem, fwdMemWb} fwdSelT;

    fwdSelT selA;
    fwdSelT selB;
    dataT   opA;
    dataT   opB;
    dataT   aluResult;
    logic   exMemFwdOk;
    logic   liveValid;
    logic   trapNow;
    logic   frozen;

    // Youngest older writer wins
    function automatic fwdSelT pickSource(regIdxT src, logic exOk, regIdxT exDst,
                                          logic wbOk, regIdxT wbDst);
        if (exOk && exDst == src) begin
            return fwdExMem;
        end
        if (wbOk && wbDst == src) begin
            return fwdMemWb;
        end
        return fwdReg;
    endfunction

    function automatic dataT muxOperand(fwdSelT sel, dataT regVal, dataT exVal, dataT wbVal);
        case (sel)
            fwdExMem: return exVal;
            fwdMemWb: return wbVal;
            default:  return regVal;
        endcase
    endfunction

    // Load data is not ready in EX/MEM; the stall covers that case
    assign exMemFwdOk = exMemValid && writesRd(exMemOp) && exMemOp != opLd && exMemRd != '0;

    assign selA = pickSource(idExRs, exMemFwdOk, exMemRd, wbValid, wbReg);
    assign selB = pickSource(idExRt, exMemFwdOk, exMemRd, wbValid, wbReg);
    assign opA  = muxOperand(selA, idExA, exMemResult, wbData);
    assign opB  = muxOperand(selB, idExB, exMemResult, wbData);

    always_comb begin
        case (idExOp)
            opAdd:        aluResult = opA + opB;
            opSub:        aluResult = opA - opB;
            opAnd:        aluResult = opA & opB;
            opOr:         aluResult = opA | opB;
            opXor:        aluResult = opA ^ opB;
            opAddi, opLd: aluResult = opA + idExImm;
            opSt:         aluResult = opA;
            default:      aluResult = '0;
        endcase
    end

    // Anything still in ID/EX after a trap is younger and dies here
    assign liveValid  = idExValid && !frozen;
    assign redirect   = liveValid && idExOp == opBeqz && opA == '0;
    assign redirectPc = idExPc + dataT'(1) + idExImm;
    assign trapNow    = liveValid && (idExOp == opHalt || !isLegal(idExOp));
    assign freeze     = frozen || trapNow;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            frozen     <= 1'b0;
            exMemValid <= 1'b0;
            exMemOp    <= opNop;
        end else begin
            if (trapNow) begin
                frozen <= 1'b1;
            end
            exMemValid <= liveValid;
            exMemOp    <= idExOp;
        end
    end

    always_ff @(posedge clk) begin
        exMemRd     <= idExRd;
        exMemResult <= aluResult;
        exMemStore  <= opB;
    end

endmodule

// File: rtl/memoryStage.sv
`timescale 1ns/1ps

module memoryStage #(
    parameter int dmemAddrWidth = 6
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             exMemValid,
    input  procPkg::opcodeT  exMemOp,
    input  procPkg::regIdxT  exMemRd,
    input  procPkg::dataT    exMemResult,
    input  procPkg::dataT    exMemStore,
    output logic             wbValid,
    output procPkg::regIdxT  wbReg,
    output procPkg::dataT    wbData,
    output logic             halted,
    output logic             err
);

    import procPkg::*;

    localparam int dmemDepth = 1 << dmemAddrWidth;

    dataT                     dmem [dmemDepth];
    logic [dmemAddrWidth-1:0] memAddr;
    dataT                     loadData;
    logic                     marker;

    // Upper address bits are dropped, so accesses wrap
    assign memAddr  = exMemResult[dmemAddrWidth-1:0];
    assign loadData = dmem[memAddr];

    // HALT or illegal op carried down from execute
    assign marker = exMemValid && (exMemOp == opHalt || !isLegal(exMemOp));

    always_ff @(posedge clk) begin
        if (exMemValid && exMemOp == opSt) begin
            dmem[memAddr] <= exMemStore;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            halted  <= 1'b0;
            err     <= 1'b0;
        end else begin
            // No retire event for r0 or for ops without a destination
            wbValid <= exMemValid && writesRd(exMemOp) && exMemRd != '0;
            if (marker) begin
                halted <= 1'b1;
            end
            if (marker && exMemOp != opHalt) begin
                err <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wbReg  <= exMemRd;
        wbData <= (exMemOp == opLd) ? loadData : exMemResult;
    end

endmodule

// File: rtl/proc.sv
`timescale 1ns/1ps

module proc #(
    parameter int imemAddrWidth = 6,
    parameter int dmemAddrWidth = 6
) (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     loadEn,
    input  logic [imemAddrWidth-1:0] loadAddr,
    input  procPkg::instrT           loadData,
    output logic                     wbValid,
    output procPkg::regIdxT          wbReg,
    output procPkg::dataT            wbData,
    output logic                     halted,
    output logic                     err
);

    import procPkg::*;

    // IF/ID
    instrT  ifIdInstr;
    dataT   ifIdPc;
    logic   ifIdValid;

    // ID/EX
    logic   idExValid;
    opcodeT idExOp;
    regIdxT idExRd;
    regIdxT idExRs;
    regIdxT idExRt;
    dataT   idExA;
    dataT   idExB;
    dataT   idExImm;
    dataT   idExPc;

    // EX/MEM
    logic   exMemValid;
    opcodeT exMemOp;
    regIdxT exMemRd;
    dataT   exMemResult;
    dataT   exMemStore;

    // Pipeline control
    logic   stall;
    logic   redirect;
    dataT   redirectPc;
    logic   freeze;

    fetchStage #(
        .imemAddrWidth(imemAddrWidth)
    ) uFetch (
        .clk(clk), .rstN(rstN), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .stall(stall), .redirect(redirect), .redirectPc(redirectPc), .freeze(freeze),
        .ifIdInstr(ifIdInstr), .ifIdPc(ifIdPc), .ifIdValid(ifIdValid)
    );

    decodeStage uDecode (
        .clk(clk), .rstN(rstN), .ifIdInstr(ifIdInstr), .ifIdPc(ifIdPc),
        .ifIdValid(ifIdValid), .redirect(redirect),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .stall(stall), .idExValid(idExValid), .idExOp(idExOp), .idExRd(idExRd),
        .idExRs(idExRs), .idExRt(idExRt), .idExA(idExA), .idExB(idExB),
        .idExImm(idExImm), .idExPc(idExPc)
    );

    executeStage uExecute (
        .clk(clk), .rstN(rstN), .idExValid(idExValid), .idExOp(idExOp), .idExRd(idExRd),
        .idExRs(idExRs), .idExRt(idExRt), .idExA(idExA), .idExB(idExB),
        .idExImm(idExImm), .idExPc(idExPc),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .redirect(redirect), .redirectPc(redirectPc), .freeze(freeze),
        .exMemValid(exMemValid), .exMemOp(exMemOp), .exMemRd(exMemRd),
        .exMemResult(exMemResult), .exMemStore(exMemStore)
    );

    memoryStage #(
        .dmemAddrWidth(dmemAddrWidth)
    ) uMemory (
        .clk(clk), .rstN(rstN), .exMemValid(exMemValid), .exMemOp(exMemOp),
        .exMemRd(exMemRd), .exMemResult(exMemResult), .exMemStore(exMemStore),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .halted(halted), .err(err)
    );

endmodule

// File: verif/proc_assert.sv
`timescale 1ns/1ps

module procAssert (
    input logic            clk,
    input logic            rstN,
    input logic            wbValid,
    input procPkg::regIdxT wbReg,
    input logic            halted,
    input logic            err
);

    // r0 is never reported as a retire target
    noR0Retire: assert property (@(posedge clk) disable iff (!rstN)
        wbValid |-> wbReg != '0)
        else $error("retire event with destination r0");

    noRetireAfterHalt: assert property (@(posedge clk) disable iff (!rstN)
        halted |-> !wbValid)
        else $error("retire event after halted");

    errNeedsHalt: assert property (@(posedge clk) disable iff (!rstN)
        err |-> halted)
        else $error("err high without halted");

    // Sticky until the next reset
    haltSticky: assert property (@(posedge clk) disable iff (!rstN)
        halted |=> halted)
        else $error("halted dropped before reset");

endmodule

bind proc procAssert uAssert (
    .clk(clk),
    .rstN(rstN),
    .wbValid(wbValid),
    .wbReg(wbReg),
    .halted(halted),
    .err(err)
);

// File: verif/procTb.sv
`timescale 1ns/1ps

module procTb;

    import procPkg::*;

    localparam int caseCount = 6;
    localparam int progLen   = 12;
    localparam int maxRetire = 8;
    localparam int timeoutCycles = 200;
    localparam int drainCycles   = 4;

    logic         clk;
    logic         rstN;
    logic         loadEn;
    logic [5:0]   loadAddr;
    instrT        loadData;
    logic         wbValid;
    regIdxT       wbReg;
    dataT         wbData;
    logic         halted;
    logic         err;

    // Program and expected retire trace per case
    instrT prog [caseCount][progLen];
    int    expReg [caseCount][maxRetire];
    int    expVal [caseCount][maxRetire];
    int    expLen [caseCount];
    logic  expErr [caseCount];

    int    gotReg [$];
    int    gotVal [$];

    proc DUT (
        .clk(clk),
        .rstN(rstN),
        .loadEn(loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData),
        .halted(halted),
        .err(err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Register-register format
    function automatic instrT encR(opcodeT op, int rd, int rs, int rt);
        return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
    endfunction

    // Immediate format with a 6-bit signed immediate
    function automatic instrT encI(opcodeT op, int rd, int rs, int imm);
        return {op, rd[2:0], rs[2:0], imm[5:0]};
    endfunction

    task automatic expectRetire(int c, int r, int v);
        expReg[c][expLen[c]] = r;
        expVal[c][expLen[c]] = v & 16'hFFFF;
        expLen[c] = expLen[c] + 1;
    endtask

    task automatic compareValue(int actual, int expected, string what);
        if (actual !== expected) begin
            $display("Fail %0t: %s got %0d expected %0d", $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic buildTable();
        for (int c = 0; c < caseCount; c++) begin
            expLen[c] = 0;
            expErr[c] = 1'b0;
            for (int i = 0; i < progLen; i++) begin
                prog[c][i] = nopInstr;
            end
        end
        // Independent ops on constants
        prog[0][0]  = encI(opAddi, 1, 0, 5);
        prog[0][1]  = encI(opAddi, 2, 0, 3);
        prog[0][2]  = encI(opAddi, 3, 0, -2);
        prog[0][6]  = encR(opAdd, 4, 1, 2);
        prog[0][7]  = encR(opSub, 5, 1, 2);
        prog[0][8]  = encR(opAnd, 6, 1, 3);
        prog[0][9]  = encR(opOr, 7, 1, 2);
        prog[0][10] = encR(opXor, 1, 1, 2);
        prog[0][11] = encI(opHalt, 0, 0, 0);
        expectRetire(0, 1, 5);
        expectRetire(0, 2, 3);
        expectRetire(0, 3, -2);
        expectRetire(0, 4, 8);
        expectRetire(0, 5, 2);
        expectRetire(0, 6, 4);
        expectRetire(0, 7, 7);
        expectRetire(0, 1, 6);
        // Dependent chain through forwarding
        prog[1][0] = encI(opAddi, 1, 0, 7);
        prog[1][1] = encI(opAddi, 2, 1, 1);
        prog[1][2] = encR(opAdd, 3, 2, 1);
        prog[1][3] = encR(opSub, 4, 3, 2);
        prog[1][4] = encR(opXor, 5, 4, 3);
        prog[1][5] = encR(opAdd, 6, 5, 5);
        prog[1][6] = encI(opHalt, 0, 0, 0);
        expectRetire(1, 1, 7);
        expectRetire(1, 2, 8);
        expectRetire(1, 3, 15);
        expectRetire(1, 4, 7);
        expectRetire(1, 5, 8);
        expectRetire(1, 6, 16);
        // Store, load and load-use
        prog[2][0] = encI(opAddi, 1, 0, 9);
        prog[2][1] = encI(opAddi, 2, 0, 20);
        prog[2][2] = encR(opSt, 0, 1, 2);
        prog[2][3] = encI(opLd, 3, 1, 0);
        prog[2][4] = encR(opAdd, 4, 3, 1);
        prog[2][5] = encI(opLd, 5, 1, 0);
        prog[2][6] = encI(opAddi, 6, 5, 1);
        prog[2][7] = encI(opHalt, 0, 0, 0);
        expectRetire(2, 1, 9);
        expectRetire(2, 2, 20);
        expectRetire(2, 3, 20);
        expectRetire(2, 4, 29);
        expectRetire(2, 5, 20);
        expectRetire(2, 6, 21);
        // Taken branch skips two and a branch not taken falls through
        prog[3][0] = encI(opAddi, 1, 0, 1);
        prog[3][1] = encI(opBeqz, 0, 0, 2);
        prog[3][2] = encI(opAddi, 2, 0, 5);
        prog[3][3] = encI(opAddi, 3, 0, 6);
        prog[3][4] = encI(opBeqz, 0, 1, 1);
        prog[3][5] = encI(opAddi, 4, 0, 7);
        prog[3][6] = encI(opAddi, 5, 0, 8);
        prog[3][7] = encI(opHalt, 0, 0, 0);
        expectRetire(3, 1, 1);
        expectRetire(3, 4, 7);
        expectRetire(3, 5, 8);
        // r0 writes are silent and nothing past HALT retires
        prog[4][0] = encI(opAddi, 0, 0, 5);
        prog[4][1] = encI(opAddi, 1, 0, 3);
        prog[4][2] = encR(opAdd, 0, 1, 1);
        prog[4][3] = encR(opAdd, 2, 1, 0);
        prog[4][4] = encI(opHalt, 0, 0, 0);
        prog[4][5] = encI(opAddi, 3, 0, 1);
        expectRetire(4, 1, 3);
        expectRetire(4, 2, 3);
        // Illegal opcode 0xA traps
        prog[5][0] = encI(opAddi, 1, 0, 4);
        prog[5][1] = encI(opAddi, 2, 0, 2);
        prog[5][2] = 16'hA000;
        prog[5][3] = encI(opAddi, 3, 0, 1);
        prog[5][4] = encI(opAddi, 4, 0, 1);
        prog[5][5] = encI(opHalt, 0, 0, 0);
        expectRetire(5, 1, 4);
        expectRetire(5, 2, 2);
        expErr[5] = 1'b1;
    endtask

    task automatic runCase(int c);
        int cycles;
        @(posedge clk);
        #1 rstN = 1'b0;
        repeat (5) @(posedge clk);
        for (int i = 0; i < progLen; i++) begin
            #1;
            loadEn   = 1'b1;
            loadAddr = 6'(i);
            loadData = prog[c][i];
            @(posedge clk);
        end
        #1 loadEn = 1'b0;
        @(posedge clk);
        #1 rstN = 1'b1;
        gotReg.delete();
        gotVal.delete();
        cycles = 0;
        while (1) begin
            @(negedge clk);
            if (wbValid) begin
                gotReg.push_back(int'(wbReg));
                gotVal.push_back(int'(wbData));
            end
            if (halted) begin
                break;
            end
            cycles++;
            if (cycles >= timeoutCycles) begin
                $display("Timeout: case %0d never reached halted", c);
                $display("RESULT: FAIL");
                $fatal(1, "timeout");
            end
        end
        // Younger instructions still in flight must never retire
        for (int i = 0; i < drainCycles; i++) begin
            @(negedge clk);
            if (wbValid) begin
                gotReg.push_back(int'(wbReg));
                gotVal.push_back(int'(wbData));
            end
            compareValue(int'(halted), 1, $sformatf("case %0d halted held", c));
        end
        compareValue(gotReg.size(), expLen[c], $sformatf("case %0d retire count", c));
        for (int i = 0; i < expLen[c]; i++) begin
            compareValue(gotReg[i], expReg[c][i], $sformatf("case %0d retire %0d reg", c, i));
            compareValue(gotVal[i], expVal[c][i], $sformatf("case %0d retire %0d value", c, i));
        end
        compareValue(int'(err), int'(expErr[c]), $sformatf("case %0d err", c));
    endtask

    initial begin
        rstN     = 1'b0;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        buildTable();
        for (int c = 0; c < caseCount; c++) begin
            runCase(c);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: all.f
rtl/procPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/proc.sv
verif/proc_assert.sv
verif/procTb.sv
